// File: decodeStage.f
+incdir+logic
logic/decodePkg.sv
logic/idStageReg.sv
logic/opDecoder.sv
logic/immGen.sv
logic/sysInstrCheck.sv
logic/decodeStage.sv
verif/decodeStage_assertions.sv
verif/decodeStage_tb.sv

// File: logic/decodePkg.sv
`default_nettype none

`include "rv64_defs.svh"

package decodePkg;

    typedef logic [`ILEN-1:0] instrWord;
    typedef logic [`XLEN-1:0] pcAddr;
    typedef logic [`IMMW-1:0] immWord;
    typedef logic [4:0]       regIdx;
    typedef logic [11:0]      csrAddr;
    typedef logic [3:0]       aluCtrl;     // ALU operation select
    typedef logic [2:0]       memOp;       // same as funct3

    // immediate layout, encodings shared with immGen
    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immU = 3'b101
    } immFmt;

    typedef enum logic [1:0] {
        bReg  = 2'd0,
        bFour = 2'd1,                      // link address pc+4
        bImm  = 2'd2,
        bZero = 2'd3                       // csr ops
    } aluBSel;

    // unsigned compares reuse brLt/brGe with aluOp 0011
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,
        brGe   = 3'b111
    } branchKind;

    typedef enum logic [1:0] {
        unitAlu = 2'd0,
        unitMul = 2'd1,
        unitDiv = 2'd2
    } execUnit;

    typedef struct packed {
        logic     valid;
        pcAddr    pc;
        instrWord instr;
        logic     instrError;              // fault from fetch
    } fetchBundle;

    typedef struct packed {
        logic      regWr;
        logic      aluASelPc;              // operand a is pc
        aluBSel    aluBSel;
        aluCtrl    aluOp;
        branchKind branch;
        logic      memRd;
        logic      memWr;
        memOp      memOp;
        execUnit   unit;
        logic      csr;
        immFmt     fmt;
        logic      fmtError;
    } ctrlBundle;

    typedef struct packed {
        logic      valid;
        pcAddr     pc;
        regIdx     rd;
        immWord    imm;
        ctrlBundle ctrl;
        logic      ebreak;
        logic      ecall;
        logic      mret;
        csrAddr    csrAddr;
        logic      illegal;
    } decodeBundle;

endpackage

`default_nettype wire

// File: logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import decodePkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              block,
    input  fetchBundle        fetchIn,
    input  logic              csrError,
    output decodeBundle       decodeOut,
    output decodePkg::csrAddr csrAddr
);

    fetchBundle stageQ;
    ctrlBundle  ctrl;
    immWord     imm;
    logic       ebreak;
    logic       ecall;
    logic       mret;
    logic       illegal;

    idStageReg stageReg_i (
        .clk     (clk),
        .reset   (reset),
        .block   (block),
        .fetchIn (fetchIn),
        .stageQ  (stageQ)
    );

    opDecoder opDecoder_i (
        .instr (stageQ.instr),
        .ctrl  (ctrl)
    );

    immGen immGen_i (
        .instr (stageQ.instr),
        .fmt   (ctrl.fmt),
        .imm   (imm)
    );

    sysInstrCheck sysCheck_i (
        .instr      (stageQ.instr),
        .csr        (ctrl.csr),
        .fmtError   (ctrl.fmtError),
        .instrError (stageQ.instrError),
        .csrError   (csrError),
        .ebreak     (ebreak),
        .ecall      (ecall),
        .mret       (mret),
        .illegal    (illegal)
    );

    assign csrAddr = stageQ.instr[31:20];  // looked up by csr file

    assign decodeOut = '{
        valid:   stageQ.valid,
        pc:      stageQ.pc,
        rd:      stageQ.instr[11:7],
        imm:     imm,
        ctrl:    ctrl,
        ebreak:  ebreak,
        ecall:   ecall,
        mret:    mret,
        csrAddr: csrAddr,
        illegal: illegal
    };

endmodule

`default_nettype wire

// File: logic/idStageReg.sv
`timescale 1ns/1ps
`default_nettype none

module idStageReg
    import decodePkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       block,
    input  fetchBundle fetchIn,
    output fetchBundle stageQ
);

    // one entry, frozen while downstream blocks
    always_ff @(posedge clk) begin
        if (!block) begin
            stageQ <= fetchIn;
        end
        if (reset) begin
            stageQ.valid <= 1'b0;          // payload left as is
        end
    end

endmodule

`default_nettype wire

// File: logic/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen
    import decodePkg::*;
(
    input  instrWord instr,
    input  immFmt    fmt,
    output immWord   imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            immS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immU: begin
                imm = {instr[31:12], 12'b0};
            end
            immJ: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};     // I type, also R/system
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/opDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module opDecoder
    import decodePkg::*;
(
    input  instrWord  instr,
    output ctrlBundle ctrl
);

    // major opcodes in instr[6:2]
    localparam logic [4:0] opLoad    = 5'b00000;
    localparam logic [4:0] opOpImm   = 5'b00100;
    localparam logic [4:0] opAuipc   = 5'b00101;
    localparam logic [4:0] opOpImm32 = 5'b00110;
    localparam logic [4:0] opStore   = 5'b01000;
    localparam logic [4:0] opOp      = 5'b01100;
    localparam logic [4:0] opLui     = 5'b01101;
    localparam logic [4:0] opOp32    = 5'b01110;
    localparam logic [4:0] opBranch  = 5'b11000;
    localparam logic [4:0] opJalr    = 5'b11001;
    localparam logic [4:0] opJal     = 5'b11011;
    localparam logic [4:0] opSystem  = 5'b11100;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       err;
    logic       mulDiv;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign mulDiv = ((opcode == opOp) || (opcode == opOp32)) && funct7[0];

    always_comb begin
        ctrl.regWr     = (opcode != opBranch) && (opcode != opStore);
        ctrl.aluASelPc = (opcode == opAuipc) || (opcode == opJal) || (opcode == opJalr);
        ctrl.memRd     = (opcode == opLoad);
        ctrl.memWr     = (opcode == opStore);
        ctrl.memOp     = funct3;
        ctrl.csr       = (opcode == opSystem);
        ctrl.unit      = unitAlu;
        if (mulDiv) begin
            ctrl.unit = funct3[2] ? unitDiv : unitMul;
        end

        ctrl.fmt     = immI;
        ctrl.aluBSel = bReg;
        ctrl.aluOp   = 4'b0000;
        ctrl.branch  = brNone;
        err          = 1'b0;

        case (opcode)
            opSystem: begin
                ctrl.aluBSel = bZero;
                ctrl.aluOp   = 4'b1111;
                err          = (funct3 == 3'b100);    // only gap in the csr space
            end
            opLui: begin
                ctrl.fmt     = immU;
                ctrl.aluBSel = bImm;
                ctrl.aluOp   = 4'b1111;               // pass b through
            end
            opAuipc: begin
                ctrl.fmt     = immU;
                ctrl.aluBSel = bImm;
            end
            opJal: begin
                ctrl.fmt     = immJ;
                ctrl.aluBSel = bFour;
                ctrl.branch  = brJal;
            end
            opJalr: begin
                ctrl.aluBSel = bFour;
                ctrl.branch  = brJalr;
                err          = (funct3 != 3'b000);
            end
            opBranch: begin
                ctrl.fmt = immB;
                case (funct3)
                    3'b000: begin
                        ctrl.aluOp  = 4'b0010;
                        ctrl.branch = brEq;
                    end
                    3'b001: begin
                        ctrl.aluOp  = 4'b0010;
                        ctrl.branch = brNe;
                    end
                    3'b100: begin
                        ctrl.aluOp  = 4'b0010;
                        ctrl.branch = brLt;
                    end
                    3'b101: begin
                        ctrl.aluOp  = 4'b0010;
                        ctrl.branch = brGe;
                    end
                    3'b110: begin
                        ctrl.aluOp  = 4'b0011;        // bltu
                        ctrl.branch = brLt;
                    end
                    3'b111: begin
                        ctrl.aluOp  = 4'b0011;        // bgeu
                        ctrl.branch = brGe;
                    end
                    default: begin
                        err = 1'b1;
                    end
                endcase
            end
            opLoad: begin
                ctrl.aluBSel = bImm;
                err          = (funct3 == 3'b111);
            end
            opStore: begin
                ctrl.fmt     = immS;
                ctrl.aluBSel = bImm;
                err          = funct3[2];             // sb..sd only
            end
            opOpImm: begin
                ctrl.aluBSel = bImm;
                ctrl.aluOp   = {funct7[5] && (funct3 == 3'b101), funct3};
                // 6-bit shamt leaves funct7[0] free
                err = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000))
                    || ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000)
                        && (funct7[6:1] != 6'b010000));
            end
            opOpImm32: begin
                ctrl.aluBSel = bImm;
                ctrl.aluOp   = {funct7[5] && (funct3 == 3'b101), funct3};
                err = (funct3 != 3'b000)
                    && ((funct3 != 3'b001) || (funct7 != 7'b0000000))
                    && ((funct3 != 3'b101)
                        || ((funct7 != 7'b0000000) && (funct7 != 7'b0100000)));
            end
            opOp: begin
                ctrl.aluOp = {funct7[5], funct3};
                err = (funct7 != 7'b0000000) && (funct7 != 7'b0100000)
                    && (funct7 != 7'b0000001);
            end
            opOp32: begin
                ctrl.aluOp = {funct7[5], funct3};
                err = (((funct7 != 7'b0000000) && (funct7 != 7'b0100000))
                        || !((funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101)))
                    && ((funct7 != 7'b0000001) || (funct3 == 3'b001)
                        || (funct3 == 3'b010) || (funct3 == 3'b011));
            end
            default: begin
                err = 1'b1;                           // unlisted opcode
            end
        endcase

        ctrl.fmtError = err || (instr[1:0] != 2'b11);
    end

endmodule

`default_nettype wire

// File: logic/rv64_defs.svh
`ifndef RV64_DEFS_SVH
`define RV64_DEFS_SVH

// base widths of the RV64 core
`define ILEN 32
`define XLEN 64
`define IMMW 32

// exact system instruction words
`define INSTR_EBREAK 32'h0010_0073
`define INSTR_ECALL  32'h0000_0073
`define INSTR_MRET   32'h3020_0073

`endif

// File: logic/sysInstrCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv64_defs.svh"

module sysInstrCheck
    import decodePkg::*;
(
    input  instrWord instr,
    input  logic     csr,                  // system opcode seen
    input  logic     fmtError,
    input  logic     instrError,
    input  logic     csrError,             // from csr file, same cycle
    output logic     ebreak,
    output logic     ecall,
    output logic     mret,
    output logic     illegal
);

    logic funct3Zero;
    logic exactSys;
    logic badPriv;
    logic badCsr;

    assign ebreak = (instr == `INSTR_EBREAK);
    assign ecall  = (instr == `INSTR_ECALL);
    assign mret   = (instr == `INSTR_MRET);

    assign funct3Zero = (instr[14:12] == 3'b000);
    assign exactSys   = ebreak || ecall || mret;

    // funct3 zero only allows the three exact words
    assign badPriv = csr && funct3Zero && !exactSys;
    assign badCsr  = csr && !funct3Zero && csrError;

    assign illegal = fmtError || instrError || badPriv || badCsr;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f decodeStage.f --top-module decodeStage_tb \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/VdecodeStage_tb)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1

// File: verif/decodeStage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage_assertions
    import decodePkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        block,
    input fetchBundle  stageQ,
    input decodeBundle decodeOut
);

    resetClearsValid: assert property (@(posedge clk) reset |=> !decodeOut.valid)
        else $error("decodeOut.valid set in the cycle after reset");

    // back-pressure freezes the whole bundle
    blockHoldsOutput: assert property (
        @(posedge clk) disable iff (reset) (block && !reset) |=> $stable(decodeOut)
    ) else $error("decodeOut changed while block was high");

    fetchErrorIsIllegal: assert property (
        @(posedge clk) stageQ.instrError |-> decodeOut.illegal
    ) else $error("held fetch error did not raise illegal");

endmodule

bind decodeStage decodeStage_assertions asserts_i (
    .clk       (clk),
    .reset     (reset),
    .block     (block),
    .stageQ    (stageQ),
    .decodeOut (decodeOut)
);

`default_nettype wire

// File: verif/decodeStage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage_tb
    import decodePkg::*;
();

    localparam logic [4:0] opLoad    = 5'b00000;
    localparam logic [4:0] opOpImm   = 5'b00100;
    localparam logic [4:0] opAuipc   = 5'b00101;
    localparam logic [4:0] opOpImm32 = 5'b00110;
    localparam logic [4:0] opStore   = 5'b01000;
    localparam logic [4:0] opOp      = 5'b01100;
    localparam logic [4:0] opLui     = 5'b01101;
    localparam logic [4:0] opOp32    = 5'b01110;
    localparam logic [4:0] opBranch  = 5'b11000;
    localparam logic [4:0] opJalr    = 5'b11001;
    localparam logic [4:0] opJal     = 5'b11011;
    localparam logic [4:0] opSystem  = 5'b11100;
    localparam logic [4:0] opTable [12] = '{opLoad, opOpImm, opAuipc, opOpImm32, opStore,
        opOp, opLui, opOp32, opBranch, opJalr, opJal, opSystem};
    localparam logic [4:0] immOps [5] = '{opLoad, opStore, opBranch, opLui, opJal};
    localparam int cycleLimit = 2500;      // tests need about 1300

    logic        clk;
    logic        reset;
    logic        block;
    logic        csrError;
    fetchBundle  fetchIn;
    decodeBundle decodeOut;
    csrAddr      csrAddrOut;

    logic [31:0] lfsrState = 32'h28c6_2333;
    logic [31:0] blockLevel;               // block odds in sixteenths
    decodeBundle expQ[$];
    decodeBundle lastExp;
    logic        haveExp = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          testErrors = 0;
    int          cycles = 0;

    decodeStage dut_i (
        .clk       (clk),
        .reset     (reset),
        .block     (block),
        .fetchIn   (fetchIn),
        .csrError  (csrError),
        .decodeOut (decodeOut),
        .csrAddr   (csrAddrOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] randOp();
        int k;
        k = int'(randBits(4) % 12);
        return opTable[k];
    endfunction

    function automatic instrWord randInstr(input logic [4:0] op);
        logic [31:0] r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        r = randBits(2);
        f7 = (r == 0) ? 7'h20 : (r == 1) ? 7'h01 : 7'h00;
        f3 = 3'(randBits(3));
        if (op == opJalr) begin
            f3 = 3'b000;
        end
        return {f7, 5'(randBits(5)), 5'(randBits(5)), f3, 5'(randBits(5)), op, 2'b11};
    endfunction

    function automatic fetchBundle mkFetch(input instrWord w, input logic err);
        fetchBundle f;
        f.valid = 1'b1;
        f.pc = {randBits(32), randBits(30) << 2};
        f.instr = w;
        f.instrError = err;
        return f;
    endfunction

    function automatic immWord sext(input logic [31:0] v, input int w);
        return immWord'($signed(v << (32 - w)) >>> (32 - w));
    endfunction

    function automatic decodeBundle refDecode(input fetchBundle f, input logic csrErr);
        decodeBundle e;
        logic [31:0] w;
        logic [4:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        legal;
        logic        isSys;
        w = f.instr;
        op = w[6:2];
        f3 = w[14:12];
        f7 = w[31:25];
        isSys = (op == opSystem);
        e = '0;
        e.valid = f.valid;
        e.pc = f.pc;
        e.rd = w[11:7];
        e.csrAddr = w[31:20];
        e.ctrl.regWr = !(op inside {opBranch, opStore});
        e.ctrl.aluASelPc = op inside {opAuipc, opJal, opJalr};
        e.ctrl.memRd = (op == opLoad);
        e.ctrl.memWr = (op == opStore);
        e.ctrl.memOp = f3;
        e.ctrl.csr = isSys;
        e.ctrl.unit = ((op inside {opOp, opOp32}) && f7[0])
                    ? (f3[2] ? unitDiv : unitMul) : unitAlu;
        e.ctrl.fmt = (op inside {opLui, opAuipc}) ? immU : (op == opJal) ? immJ
                   : (op == opBranch) ? immB : (op == opStore) ? immS : immI;
        e.ctrl.aluBSel = isSys ? bZero : (op inside {opJal, opJalr}) ? bFour
                       : (op inside {opLui, opAuipc, opLoad, opStore, opOpImm, opOpImm32})
                       ? bImm : bReg;
        e.ctrl.branch = (op == opJal) ? brJal : (op == opJalr) ? brJalr : brNone;
        legal = 1'b1;
        case (op)
            opSystem: begin
                legal = (f3 != 3'b100);
                e.ctrl.aluOp = 4'hf;
            end
            opLui: e.ctrl.aluOp = 4'hf;
            opAuipc, opJal: legal = 1'b1;
            opJalr: legal = (f3 == 3'b000);
            opBranch: begin
                legal = (f3 != 3'b010) && (f3 != 3'b011);
                if (legal) begin
                    e.ctrl.aluOp = {3'b001, f3[2] & f3[1]};    // unsigned for ltu/geu
                    e.ctrl.branch = (f3 == 3'b000) ? brEq : (f3 == 3'b001) ? brNe
                                  : f3[0] ? brGe : brLt;
                end
            end
            opLoad: legal = (f3 != 3'b111);
            opStore: legal = !f3[2];
            opOpImm: begin
                legal = !(f3 inside {3'b001, 3'b101}) || (f7[6:1] == 6'h00)
                      || ((f3 == 3'b101) && (f7[6:1] == 6'h10));
                e.ctrl.aluOp = {f7[5] && (f3 == 3'b101), f3};
            end
            opOpImm32: begin
                legal = (f3 == 3'b000) || ((f3 == 3'b001) && (f7 == 7'h00))
                      || ((f3 == 3'b101) && (f7 inside {7'h00, 7'h20}));
                e.ctrl.aluOp = {f7[5] && (f3 == 3'b101), f3};
            end
            opOp: begin
                legal = f7 inside {7'h00, 7'h20, 7'h01};
                e.ctrl.aluOp = {f7[5], f3};
            end
            opOp32: begin
                legal = ((f7 inside {7'h00, 7'h20}) && (f3 inside {3'b000, 3'b001, 3'b101}))
                      || ((f7 == 7'h01) && !(f3 inside {3'b001, 3'b010, 3'b011}));
                e.ctrl.aluOp = {f7[5], f3};
            end
            default: legal = 1'b0;
        endcase
        e.ctrl.fmtError = !legal || (w[1:0] != 2'b11);
        e.ebreak = (w == 32'h0010_0073);
        e.ecall = (w == 32'h0000_0073);
        e.mret = (w == 32'h3020_0073);
        e.illegal = e.ctrl.fmtError || f.instrError
                  || (isSys && (f3 == 3'b000) && !(e.ebreak || e.ecall || e.mret))
                  || (isSys && (f3 != 3'b000) && csrErr);
        case (e.ctrl.fmt)
            immU: e.imm = {w[31:12], 12'h000};
            immS: e.imm = sext(32'({w[31:25], w[11:7]}), 12);
            immB: e.imm = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            immJ: e.imm = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            default: e.imm = sext(32'(w[31:20]), 12);
        endcase
        return e;
    endfunction

    task automatic checkField(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            testErrors++;
            $display("[FAIL] time %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic compareOut(input decodeBundle e);
        checkField("valid", 64'(e.valid), 64'(decodeOut.valid));
        checkField("pc", e.pc, decodeOut.pc);
        checkField("rd", 64'(e.rd), 64'(decodeOut.rd));
        checkField("imm", 64'(e.imm), 64'(decodeOut.imm));
        checkField("ctrl", 64'(e.ctrl), 64'(decodeOut.ctrl));
        checkField("ebreak/ecall/mret", 64'({e.ebreak, e.ecall, e.mret}),
                   64'({decodeOut.ebreak, decodeOut.ecall, decodeOut.mret}));
        checkField("csrAddr", 64'(e.csrAddr), 64'(decodeOut.csrAddr));
        checkField("csrAddr port", 64'(e.csrAddr), 64'(csrAddrOut));
        checkField("illegal", 64'(e.illegal), 64'(decodeOut.illegal));
    endtask

    // holds the item until an edge with block low takes it
    task automatic offer(input fetchBundle f, input logic ce);
        logic held;
        held = 1'b1;
        while (held) begin
            held = (randBits(4) < blockLevel);
            block = held;
            fetchIn = f;
            @(posedge clk);
            #2;
        end
        expQ.push_back(refDecode(f, ce));
        csrError = ce;                     // csr file answers for the held entry
    endtask

    task automatic finishTest(input string name);
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        $display("test %s finished with %0d mismatches", name, testErrors);
        testErrors = 0;
    endtask

    // compares at the falling edge and rechecks the held output between accepts
    always @(negedge clk) begin
        if (expQ.size() != 0) begin
            lastExp = expQ.pop_front();
            haveExp = 1'b1;
        end
        if (haveExp) begin
            compareOut(lastExp);
        end
    end

    initial begin
        fetchBundle  f;
        instrWord    w;
        logic [24:0] upper;
        reset = 1'b1;
        block = 1'b0;
        csrError = 1'b0;
        blockLevel = 2;
        fetchIn = mkFetch(randBits(32), 1'b0);
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        block = 1'b1;
        @(negedge clk);
        checkField("valid after reset", 64'h0, 64'(decodeOut.valid));
        @(posedge clk);
        #2;
        for (int i = 0; i < 3; i++) begin
            f = mkFetch(randInstr(randOp()), 1'b0);
            f.valid = 1'b0;
            offer(f, 1'b0);
        end
        finishTest("reset");

        for (int i = 0; i < 400; i++) begin
            offer(mkFetch(randInstr(randOp()), 1'b0), randBits(1) == 1);
        end
        finishTest("random legal");

        for (int i = 0; i < 100; i++) begin
            case (i / 5)
                0: upper = '1;
                1: upper = '0;
                2: upper = 25'h155_5555;
                3: upper = 25'h0aa_aaaa;
                default: upper = 25'(randBits(25));
            endcase
            offer(mkFetch({upper, immOps[i % 5], 2'b11}, 1'b0), 1'b0);
        end
        finishTest("immediates");

        for (int i = 0; i < 160; i++) begin
            case (i % 4)
                0: w = randBits(32);
                1: w = {7'(randBits(7)), 18'(randBits(18)), randOp(), 2'b11};
                2: begin
                    w = randInstr(randOp());
                    w[1:0] = 2'(randBits(2) % 3);
                end
                default: w = randInstr(randOp());
            endcase
            offer(mkFetch(w, (i % 4) == 3), randBits(1) == 1);
        end
        finishTest("illegal detection");

        for (int i = 0; i < 100; i++) begin
            case (i)
                0: w = 32'h0010_0073;
                1: w = 32'h0000_0073;
                2: w = 32'h3020_0073;
                default: begin
                    w = randInstr(opSystem);
                    if ((i % 2) == 0) begin
                        w[14:12] = 3'b000;
                    end
                end
            endcase
            offer(mkFetch(w, 1'b0), randBits(1) == 1);
        end
        finishTest("system instructions");

        blockLevel = 8;
        for (int i = 0; i < 200; i++) begin
            f = mkFetch(randInstr(randOp()), 1'b0);
            f.valid = (randBits(2) != 0);
            offer(f, randBits(1) == 1);
        end
        finishTest("back-pressure");

        $display("checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
